/* verilog/snoop_pkg.sv */
// Shared widths for the control-flow trace snooper
// Hart trace event and repacked record layouts
// Register port request and response types
// Register map addresses

package snoop_pkg;

  localparam int XLEN       = 64;
  localparam int WORD_W     = 32;
  localparam int CFG_ADDR_W = 4;
  localparam int HART_SEL_W = 3;
  localparam int DROP_W     = 16;

  // ----------------------------------------
  // Trace types
  // ----------------------------------------

  // One control-flow event as a hart emits it
  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   src_pc;
    logic [XLEN-1:0]   dst_pc;
    logic [3:0]        cf_type;
    logic [1:0]        priv;
    logic [WORD_W-1:0] instr;
  } hart_trace_t;

  // Record as stored in the FIFO and sent to the collector
  typedef struct packed {
    logic [1:0]        priv;
    logic [WORD_W-1:0] pc_src_h;
    logic [WORD_W-1:0] pc_src_l;
    logic [WORD_W-1:0] pc_dst_h;
    logic [WORD_W-1:0] pc_dst_l;
    logic [WORD_W-1:0] metadata;
    logic [WORD_W-1:0] opcode;
  } trace_rec_t;

  // ----------------------------------------
  // Register port
  // ----------------------------------------

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [CFG_ADDR_W-1:0] addr;
    logic [WORD_W-1:0]     wdata;
  } cfg_req_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] rdata;
  } cfg_rsp_t;

  // Register map
  localparam logic [CFG_ADDR_W-1:0] REG_CTRL        = 4'd0;
  localparam logic [CFG_ADDR_W-1:0] REG_WATERMARK   = 4'd1;
  localparam logic [CFG_ADDR_W-1:0] REG_TRIG_OPCODE = 4'd2;
  localparam logic [CFG_ADDR_W-1:0] REG_STATUS      = 4'd3;

endpackage

/* verilog/trace_select.sv */
// Hart trace multiplexer
// Repacks the selected hart's event into the record layout

`timescale 1ns/1ps

module trace_select import snoop_pkg::*; #(
  parameter int NUM_HARTS = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  hart_trace_t [NUM_HARTS-1:0] hart_trace_i,
  input  logic                        enable_i,
  input  logic [HART_SEL_W-1:0]       hart_sel_i,
  output trace_rec_t                  rec_o,
  output logic                        push_o
);

  hart_trace_t sel_trace;
  trace_rec_t  rec_q;
  logic        push_q;

  // Unused harts and out-of-range selects read as an idle hart
  always_comb begin
    sel_trace = '0;
    for (int i = 0; i < NUM_HARTS; i++) begin
      if (hart_sel_i == HART_SEL_W'(i)) begin
        sel_trace = hart_trace_i[i];
      end
    end
  end

  // PC halves drop bit 63 and bit 0
  always_ff @(posedge clk_i) begin
    rec_q.priv     <= sel_trace.priv;
    rec_q.pc_src_h <= {1'b0, sel_trace.src_pc[62:32]};
    rec_q.pc_src_l <= {sel_trace.src_pc[31:1], 1'b0};
    rec_q.pc_dst_h <= {1'b0, sel_trace.dst_pc[62:32]};
    rec_q.pc_dst_l <= {sel_trace.dst_pc[31:1], 1'b0};
    rec_q.metadata <= {{(WORD_W-4){1'b0}}, sel_trace.cf_type};
    rec_q.opcode   <= sel_trace.instr;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      push_q <= 1'b0;
    end else begin
      push_q <= enable_i && sel_trace.valid;
    end
  end

  assign rec_o  = rec_q;
  assign push_o = push_q;

  // Software must never enable tracing on a hart that does not exist
  a_hart_sel_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    enable_i |-> (hart_sel_i < NUM_HARTS))
    else $error("hart select out of range");

endmodule

/* verilog/snoop_cfg_regs.sv */
// Configuration and status registers
// Control, watermark and trigger opcode storage, read mux,
// status write clear pulse for the trigger flag

`timescale 1ns/1ps

module snoop_cfg_regs import snoop_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  cfg_req_t              cfg_req_i,
  output cfg_rsp_t              cfg_rsp_o,
  output logic                  enable_o,
  output logic [HART_SEL_W-1:0] hart_sel_o,
  output logic [WORD_W-1:0]     watermark_o,
  output logic [WORD_W-1:0]     trig_opcode_o,
  input  logic                  trig_flag_i,
  output logic                  trig_clear_o,
  input  logic [DROP_W-1:0]     drop_count_i
);

  logic                  enable_q;
  logic [HART_SEL_W-1:0] hart_sel_q;
  logic [WORD_W-1:0]     watermark_q;
  logic [WORD_W-1:0]     trig_opcode_q;
  logic                  wr_en;
  logic                  rd_en;
  logic [WORD_W-1:0]     rdata_d;
  logic [WORD_W-1:0]     rdata_q;
  logic                  rsp_valid_q;

  assign wr_en = cfg_req_i.valid && cfg_req_i.write;
  assign rd_en = cfg_req_i.valid && !cfg_req_i.write;

  // ----------------------------------------
  // Write decode
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q      <= 1'b0;
      hart_sel_q    <= '0;
      watermark_q   <= '0;
      trig_opcode_q <= '0;
    end else if (wr_en) begin
      case (cfg_req_i.addr)
        REG_CTRL: begin
          enable_q   <= cfg_req_i.wdata[0];
          hart_sel_q <= cfg_req_i.wdata[HART_SEL_W:1];
        end
        REG_WATERMARK:   watermark_q   <= cfg_req_i.wdata;
        REG_TRIG_OPCODE: trig_opcode_q <= cfg_req_i.wdata;
        default: ;
      endcase
    end
  end

  // Any write to status clears the sticky flag
  assign trig_clear_o = wr_en && (cfg_req_i.addr == REG_STATUS);

  // ----------------------------------------
  // Read path, one cycle latency
  // ----------------------------------------

  always_comb begin
    case (cfg_req_i.addr)
      REG_CTRL:        rdata_d = {{(WORD_W-1-HART_SEL_W){1'b0}}, hart_sel_q, enable_q};
      REG_WATERMARK:   rdata_d = watermark_q;
      REG_TRIG_OPCODE: rdata_d = trig_opcode_q;
      REG_STATUS:      rdata_d = {drop_count_i, {(WORD_W-DROP_W-1){1'b0}}, trig_flag_i};
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rsp_o.valid = rsp_valid_q;
  assign cfg_rsp_o.rdata = rdata_q;
  assign enable_o        = enable_q;
  assign hart_sel_o      = hart_sel_q;
  assign watermark_o     = watermark_q;
  assign trig_opcode_o   = trig_opcode_q;

endmodule

/* verilog/trace_fifo.sv */
// Record FIFO
// Circular buffer with fill level and saturating drop counter

`timescale 1ns/1ps

module trace_fifo import snoop_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              push_i,
  input  trace_rec_t        rec_i,
  input  logic              pop_i,
  output trace_rec_t        rec_o,
  output logic              empty_o,
  output logic [WORD_W-1:0] level_o,
  output logic [DROP_W-1:0] drop_count_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

  trace_rec_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [LVL_W-1:0]  count_q;
  logic [DROP_W-1:0] drop_q;
  logic              full;
  logic              do_push;
  logic              do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == LVL_W'(FIFO_DEPTH));
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= rec_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      drop_q   <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + LVL_W'(do_push) - LVL_W'(do_pop);
      // Hart traces cannot stall, so a full FIFO loses the record
      if (push_i && full && (drop_q != '1)) begin
        drop_q <= drop_q + 1'b1;
      end
    end
  end

  assign rec_o        = mem[rd_ptr_q];
  assign empty_o      = (count_q == '0);
  assign level_o      = WORD_W'(count_q);
  assign drop_count_o = drop_q;

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o)
    else $error("pop while FIFO empty");

  a_level_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= LVL_W'(FIFO_DEPTH))
    else $error("FIFO level above depth");

endmodule

/* verilog/snoop_irq.sv */
// Snooper interrupts
// Registered watermark comparison and sticky opcode trigger

`timescale 1ns/1ps

module snoop_irq import snoop_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              push_i,
  input  logic [WORD_W-1:0] opcode_i,
  input  logic [WORD_W-1:0] level_i,
  input  logic [WORD_W-1:0] watermark_i,
  input  logic [WORD_W-1:0] trig_opcode_i,
  input  logic              trig_clear_i,
  output logic              trig_flag_o,
  output logic              watermark_irq_o,
  output logic              trigger_irq_o
);

  logic trig_flag_q;
  logic wm_irq_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      trig_flag_q <= 1'b0;
      wm_irq_q    <= 1'b0;
    end else begin
      // A matching record in the same cycle as a clear keeps the flag set
      if (push_i && (opcode_i == trig_opcode_i)) begin
        trig_flag_q <= 1'b1;
      end else if (trig_clear_i) begin
        trig_flag_q <= 1'b0;
      end
      // Zero watermark disables the level interrupt
      wm_irq_q <= (watermark_i != '0) && (level_i >= watermark_i);
    end
  end

  assign trig_flag_o     = trig_flag_q;
  assign trigger_irq_o   = trig_flag_q;
  assign watermark_irq_o = wm_irq_q;

endmodule

/* verilog/credit_tx.sv */
// Credit-based record sender
// Credit counter with simultaneous return and spend,
// FIFO pop control and registered record output

`timescale 1ns/1ps

module credit_tx import snoop_pkg::*; #(
  parameter int MAX_CREDITS = 4
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       empty_i,
  input  trace_rec_t rec_i,
  output logic       pop_o,
  input  logic       credit_i,
  output trace_rec_t rec_o,
  output logic       rec_valid_o
);

  localparam int CRED_W = $clog2(MAX_CREDITS + 1);

  logic [CRED_W-1:0] credits_q;
  logic              pop;
  trace_rec_t        rec_q;
  logic              rec_valid_q;

  // Send whenever a record is queued and the collector has room
  assign pop = !empty_i && (credits_q != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credits_q   <= CRED_W'(MAX_CREDITS);
      rec_valid_q <= 1'b0;
    end else begin
      case ({credit_i, pop})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
      rec_valid_q <= pop;
    end
  end

  // Output stage
  always_ff @(posedge clk_i) begin
    if (pop) begin
      rec_q <= rec_i;
    end
  end

  assign pop_o       = pop;
  assign rec_o       = rec_q;
  assign rec_valid_o = rec_valid_q;

  // Collector must not return more credits than it was given
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_q <= CRED_W'(MAX_CREDITS))
    else $error("credit count above maximum");

  a_send_with_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rec_valid_o |-> ($past(credits_q) != '0))
    else $error("record sent without credit");

endmodule

/* verilog/snoop_top.sv */
// Control-flow trace snooper top level
// Hart selection, configuration registers, record FIFO,
// interrupt logic and credit-based record output

`timescale 1ns/1ps

module snoop_top import snoop_pkg::*; #(
  parameter int NUM_HARTS   = 2,
  parameter int FIFO_DEPTH  = 8,
  parameter int MAX_CREDITS = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  hart_trace_t [NUM_HARTS-1:0]   hart_trace_i,
  input  cfg_req_t                      cfg_req_i,
  output cfg_rsp_t                      cfg_rsp_o,
  output trace_rec_t                    rec_o,
  output logic                          rec_valid_o,
  input  logic                          credit_i,
  output logic                          watermark_irq_o,
  output logic                          trigger_irq_o
);

  // Configuration
  logic                  enable;
  logic [HART_SEL_W-1:0] hart_sel;
  logic [WORD_W-1:0]     watermark;
  logic [WORD_W-1:0]     trig_opcode;
  logic                  trig_flag;
  logic                  trig_clear;
  logic [DROP_W-1:0]     drop_count;

  // Record path
  trace_rec_t        sel_rec;
  logic              sel_push;
  trace_rec_t        fifo_rec;
  logic              fifo_empty;
  logic              fifo_pop;
  logic [WORD_W-1:0] fifo_level;

  trace_select #(
    .NUM_HARTS ( NUM_HARTS )
  ) i_trace_select (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .hart_trace_i ( hart_trace_i ),
    .enable_i     ( enable       ),
    .hart_sel_i   ( hart_sel     ),
    .rec_o        ( sel_rec      ),
    .push_o       ( sel_push     )
  );

  snoop_cfg_regs i_cfg_regs (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .cfg_req_i     ( cfg_req_i   ),
    .cfg_rsp_o     ( cfg_rsp_o   ),
    .enable_o      ( enable      ),
    .hart_sel_o    ( hart_sel    ),
    .watermark_o   ( watermark   ),
    .trig_opcode_o ( trig_opcode ),
    .trig_flag_i   ( trig_flag   ),
    .trig_clear_o  ( trig_clear  ),
    .drop_count_i  ( drop_count  )
  );

  trace_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_trace_fifo (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .push_i       ( sel_push   ),
    .rec_i        ( sel_rec    ),
    .pop_i        ( fifo_pop   ),
    .rec_o        ( fifo_rec   ),
    .empty_o      ( fifo_empty ),
    .level_o      ( fifo_level ),
    .drop_count_o ( drop_count )
  );

  snoop_irq i_snoop_irq (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .push_i          ( sel_push        ),
    .opcode_i        ( sel_rec.opcode  ),
    .level_i         ( fifo_level      ),
    .watermark_i     ( watermark       ),
    .trig_opcode_i   ( trig_opcode     ),
    .trig_clear_i    ( trig_clear      ),
    .trig_flag_o     ( trig_flag       ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   )
  );

  credit_tx #(
    .MAX_CREDITS ( MAX_CREDITS )
  ) i_credit_tx (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .empty_i     ( fifo_empty  ),
    .rec_i       ( fifo_rec    ),
    .pop_o       ( fifo_pop    ),
    .credit_i    ( credit_i    ),
    .rec_o       ( rec_o       ),
    .rec_valid_o ( rec_valid_o )
  );

endmodule

/* sim/tb_snoop_top.sv */
// Testbench for the control-flow trace snooper
// Event table with expected repacked records, credit-returning collector,
// register, flow-control, drop, watermark and trigger checks

`timescale 1ns/1ps

module tb_snoop_top import snoop_pkg::*; ();

  localparam int NUM_HARTS   = 2;
  localparam int FIFO_DEPTH  = 8;
  localparam int MAX_CREDITS = 4;
  localparam int NUM_EV      = 16;
  localparam int TIMEOUT     = 200;
  localparam int DRIVE_DLY   = 1;
  localparam int WM_LEVEL    = 6;
  localparam logic [WORD_W-1:0] TRIG_INSTR = 32'h0010_0073;

  // Table row with the emitting hart and its event
  typedef struct packed {
    logic        hart;
    hart_trace_t trace;
  } tbl_entry_t;

  logic                        clk_i;
  logic                        rst_n_i;
  hart_trace_t [NUM_HARTS-1:0] hart_trace_i;
  cfg_req_t                    cfg_req_i;
  cfg_rsp_t                    cfg_rsp_o;
  trace_rec_t                  rec_o;
  logic                        rec_valid_o;
  logic                        credit_i;
  logic                        watermark_irq_o;
  logic                        trigger_irq_o;

  tbl_entry_t tbl [NUM_EV];
  trace_rec_t exp_tbl [NUM_EV];
  trace_rec_t got_q [$];
  integer     seed;
  int         errors;
  bit         auto_credit;
  int         pending_credits;

  snoop_top #(
    .NUM_HARTS   ( NUM_HARTS   ),
    .FIFO_DEPTH  ( FIFO_DEPTH  ),
    .MAX_CREDITS ( MAX_CREDITS )
  ) uut (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .hart_trace_i    ( hart_trace_i    ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_rsp_o       ( cfg_rsp_o       ),
    .rec_o           ( rec_o           ),
    .rec_valid_o     ( rec_valid_o     ),
    .credit_i        ( credit_i        ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Collector samples records at the falling edge
  always @(negedge clk_i) begin
    if (rec_valid_o === 1'b1) begin
      got_q.push_back(rec_o);
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic abort(input string why);
    errors++;
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      abort($sformatf("Fail %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t exp);
    if (got !== exp) begin
      abort($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Expected record with bit 63 and bit 0 of each PC cleared
  function automatic trace_rec_t repack(input hart_trace_t t);
    trace_rec_t r;
    r.priv     = t.priv;
    r.pc_src_h = t.src_pc[63:32] & 32'h7fff_ffff;
    r.pc_src_l = t.src_pc[31:0] & 32'hffff_fffe;
    r.pc_dst_h = t.dst_pc[63:32] & 32'h7fff_ffff;
    r.pc_dst_l = t.dst_pc[31:0] & 32'hffff_fffe;
    r.metadata = {28'h0, t.cf_type};
    r.opcode   = t.instr;
    return r;
  endfunction

  task automatic build_table();
    for (int i = 0; i < NUM_EV; i++) begin
      tbl[i].hart          = i[0];
      tbl[i].trace.valid   = 1'b1;
      tbl[i].trace.src_pc  = {$random(seed), $random(seed)};
      tbl[i].trace.dst_pc  = {$random(seed), $random(seed)};
      tbl[i].trace.cf_type = 4'(i);
      tbl[i].trace.priv    = 2'($random(seed));
      tbl[i].trace.instr   = 32'h0000_0063 | (32'(i) << 12);
      exp_tbl[i] = repack(tbl[i].trace);
    end
  endtask

  // Advance one cycle and return inputs to idle
  task automatic tick();
    @(posedge clk_i);
    #DRIVE_DLY;
    cfg_req_i    = '0;
    hart_trace_i = '0;
    // Collector returns one credit per cycle
    if (auto_credit && rec_valid_o) begin
      pending_credits++;
    end
    credit_i = (pending_credits > 0);
    if (credit_i) begin
      pending_credits--;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic give_credit(input int n);
    pending_credits += n;
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
    cfg_req_i.valid = 1'b1;
    cfg_req_i.write = 1'b1;
    cfg_req_i.addr  = addr;
    cfg_req_i.wdata = data;
    tick();
  endtask

  task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr, output logic [WORD_W-1:0] data);
    cfg_req_i.valid = 1'b1;
    cfg_req_i.write = 1'b0;
    cfg_req_i.addr  = addr;
    cfg_req_i.wdata = '0;
    tick();
    if (cfg_rsp_o.valid !== 1'b1) begin
      abort($sformatf("no read response one cycle after reading address %0d", addr));
    end
    data = cfg_rsp_o.rdata;
  endtask

  task automatic send_trace(input int hart, input hart_trace_t t);
    hart_trace_i[hart] = t;
    tick();
  endtask

  task automatic wait_records(input int n);
    int cycles;
    cycles = 0;
    while (got_q.size() < n && cycles < TIMEOUT) begin
      tick();
      cycles++;
    end
    if (got_q.size() < n) begin
      abort($sformatf("timeout waiting for %0d records, only %0d arrived", n, got_q.size()));
    end
  endtask

  task automatic wait_irq(input bit trig, input logic level, input string name);
    int cycles;
    cycles = 0;
    while (((trig ? trigger_irq_o : watermark_irq_o) !== level) && cycles < TIMEOUT) begin
      tick();
      cycles++;
    end
    if ((trig ? trigger_irq_o : watermark_irq_o) !== level) begin
      abort($sformatf("timeout waiting for %s to become %0d", name, level));
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    logic [WORD_W-1:0] rd;
    int                n_exp;
    trace_rec_t        exp_q [$];
    hart_trace_t       t;

    seed            = 32'hedf21994;
    errors          = 0;
    auto_credit     = 1'b0;
    pending_credits = 0;
    rst_n_i         = 1'b0;
    cfg_req_i       = '0;
    hart_trace_i    = '0;
    credit_i        = 1'b0;
    build_table();
    repeat (2) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;

    // Register reset values and read back
    cfg_read(REG_CTRL, rd);
    check_word("ctrl", rd, 32'h0);
    cfg_read(REG_WATERMARK, rd);
    check_word("watermark", rd, 32'h0);
    cfg_read(REG_TRIG_OPCODE, rd);
    check_word("trig_opcode", rd, 32'h0);
    cfg_read(REG_STATUS, rd);
    check_word("status", rd, 32'h0);
    // Zero watermark keeps the level interrupt quiet
    check_word("watermark_irq_o", WORD_W'(watermark_irq_o), 32'h0);
    check_word("trigger_irq_o", WORD_W'(trigger_irq_o), 32'h0);
    cfg_write(REG_CTRL, 32'h3);
    cfg_read(REG_CTRL, rd);
    check_word("ctrl", rd, 32'h3);
    cfg_write(REG_WATERMARK, 32'h0000_000a);
    cfg_read(REG_WATERMARK, rd);
    check_word("watermark", rd, 32'h0000_000a);
    cfg_write(REG_TRIG_OPCODE, 32'hdead_beef);
    cfg_read(REG_TRIG_OPCODE, rd);
    check_word("trig_opcode", rd, 32'hdead_beef);
    cfg_read(4'hc, rd);
    check_word("unused register", rd, 32'h0);
    cfg_write(REG_CTRL, 32'h0);

    // Only the selected hart's table events reach the output
    auto_credit = 1'b1;
    for (int sel = 0; sel < NUM_HARTS; sel++) begin
      cfg_write(REG_CTRL, (32'(sel) << 1) | 32'h1);
      got_q.delete();
      exp_q.delete();
      for (int i = 0; i < NUM_EV; i++) begin
        if (int'(tbl[i].hart) == sel) begin
          exp_q.push_back(exp_tbl[i]);
        end
        send_trace(int'(tbl[i].hart), tbl[i].trace);
      end
      wait_records(exp_q.size());
      idle(10);
      check_word("record count", WORD_W'(got_q.size()), WORD_W'(exp_q.size()));
      for (int i = 0; i < exp_q.size(); i++) begin
        check_rec("rec_o", got_q[i], exp_q[i]);
      end
    end

    // Each returned credit releases exactly one record
    auto_credit = 1'b0;
    cfg_write(REG_CTRL, 32'h1);
    got_q.delete();
    for (int i = 0; i < 6; i++) begin
      send_trace(0, tbl[i].trace);
    end
    wait_records(MAX_CREDITS);
    idle(10);
    check_word("record count", WORD_W'(got_q.size()), WORD_W'(MAX_CREDITS));
    for (int c = 1; c <= 2; c++) begin
      give_credit(1);
      wait_records(MAX_CREDITS + c);
      idle(6);
      check_word("record count", WORD_W'(got_q.size()), WORD_W'(MAX_CREDITS + c));
    end
    for (int i = 0; i < 6; i++) begin
      check_rec("rec_o", got_q[i], exp_tbl[i]);
    end
    give_credit(MAX_CREDITS);
    idle(8);

    // Overflow drops and the watermark interrupt
    cfg_write(REG_WATERMARK, WORD_W'(WM_LEVEL));
    got_q.delete();
    n_exp = FIFO_DEPTH + MAX_CREDITS;
    for (int i = 0; i < FIFO_DEPTH + MAX_CREDITS + 3; i++) begin
      send_trace(0, tbl[i].trace);
      // Level behind the interrupt holds the first i-1 events minus those sent on credit
      check_word("watermark_irq_o", WORD_W'(watermark_irq_o),
                 WORD_W'((i - 1 - MAX_CREDITS) >= WM_LEVEL));
    end
    wait_records(MAX_CREDITS);
    wait_irq(1'b0, 1'b1, "watermark_irq_o");
    idle(3);
    cfg_read(REG_STATUS, rd);
    check_word("status", rd, 32'h0003_0000);
    check_word("watermark_irq_o", WORD_W'(watermark_irq_o), 32'h1);
    give_credit(MAX_CREDITS);
    auto_credit = 1'b1;
    wait_records(n_exp);
    wait_irq(1'b0, 1'b0, "watermark_irq_o");
    idle(10);
    check_word("record count", WORD_W'(got_q.size()), WORD_W'(n_exp));
    for (int i = 0; i < n_exp; i++) begin
      check_rec("rec_o", got_q[i], exp_tbl[i]);
    end

    // Sticky trigger until a status write
    cfg_write(REG_TRIG_OPCODE, TRIG_INSTR);
    check_word("trigger_irq_o", WORD_W'(trigger_irq_o), 32'h0);
    got_q.delete();
    t       = tbl[0].trace;
    t.instr = TRIG_INSTR;
    send_trace(0, t);
    wait_irq(1'b1, 1'b1, "trigger_irq_o");
    send_trace(0, tbl[1].trace);
    idle(5);
    check_word("trigger_irq_o", WORD_W'(trigger_irq_o), 32'h1);
    cfg_read(REG_STATUS, rd);
    check_word("status", rd, 32'h0003_0001);
    cfg_write(REG_STATUS, 32'h0);
    check_word("trigger_irq_o", WORD_W'(trigger_irq_o), 32'h0);
    cfg_read(REG_STATUS, rd);
    check_word("status", rd, 32'h0003_0000);
    wait_records(2);
    check_rec("rec_o", got_q[0], repack(t));
    check_rec("rec_o", got_q[1], exp_tbl[1]);

    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/snoop_pkg.sv
verilog/trace_select.sv
verilog/snoop_cfg_regs.sv
verilog/trace_fifo.sv
verilog/snoop_irq.sv
verilog/credit_tx.sv
verilog/snoop_top.sv
sim/tb_snoop_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the snooper testbench with Verilator

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_snoop_top \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_snoop_top > sim.log 2>&1
cat sim.log
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
